// File: build.f
hw/fu_pkg.sv
hw/fu_issue_if.sv
hw/operand_forward.sv
hw/int_alu.sv
hw/int_shifter.sv
hw/result_stage.sv
hw/fu_alu_cluster.sv
testbench/tb_fu_alu_cluster.sv

// File: Bender.yml
package:
  name: fu_alu_cluster

sources:
  - hw/fu_pkg.sv
  - hw/fu_issue_if.sv
  - hw/operand_forward.sv
  - hw/int_alu.sv
  - hw/int_shifter.sv
  - hw/result_stage.sv
  - hw/fu_alu_cluster.sv
  - target: test
    files:
      - testbench/tb_fu_alu_cluster.sv

// File: testbench/tb_fu_alu_cluster.sv
`timescale 1ns/10ps

module tb_fu_alu_cluster;
  import fu_pkg::*;

  typedef struct packed {
    word_t  res;
    flags_t flg;
    logic   ok;
  } exp_t;

  logic     clk, rst, except;
  logic     en_in [2];
  op_t      op_in [2];
  word_t    a_in [2], b_in [2], ext_bus [2];
  flags_t   s_in [2], ext_flg [2];
  fwd_sel_t a_f [2], a_p [2], b_f [2], b_p [2], s_f [2], s_p [2];
  ret_t     u0_ret, u1_ret;
  logic     u0_rten, u1_rten;
  word_t    u0_res, u1_res;

  // model of the lane buses with flags held zero-extended.
  word_t  m_res [2], m_flg [2];
  ret_t   m_ret [2];
  logic   m_rten [2];
  word_t  m_bus_prev [num_buses], m_flg_prev [num_buses];

  logic [31:0] rng = 32'h939b;
  int          errors = 0, n_expected = 0, n_got = 0, n_pass = 0, n_fail = 0;
  bit          timed_out = 0;
  op_t         alu_ops [6] = '{op_add, op_sub, op_and, op_or, op_xor, op_cmp};
  op_t         sh_ops [6] = '{op_shl64, op_shr64, op_sar64, op_shl32, op_shr32, op_sar32};
  op_t         bad_ops [3] = '{8'h00, 8'h13, 8'hff};
  logic [5:0]  amts [4] = '{6'd0, 6'd31, 6'd32, 6'd63};

  fu_alu_cluster i_fu_alu_cluster (
    .clk, .rst, .except,
    .u0_clk_en(en_in[0]), .u0_op(op_in[0]), .u0_a(a_in[0]), .u0_b(b_in[0]), .u0_s(s_in[0]),
    .u0_a_fwd(a_f[0]), .u0_a_fwd_prev(a_p[0]), .u0_b_fwd(b_f[0]), .u0_b_fwd_prev(b_p[0]),
    .u0_s_fwd(s_f[0]), .u0_s_fwd_prev(s_p[0]),
    .u1_clk_en(en_in[1]), .u1_op(op_in[1]), .u1_a(a_in[1]), .u1_b(b_in[1]), .u1_s(s_in[1]),
    .u1_a_fwd(a_f[1]), .u1_a_fwd_prev(a_p[1]), .u1_b_fwd(b_f[1]), .u1_b_fwd_prev(b_p[1]),
    .u1_s_fwd(s_f[1]), .u1_s_fwd_prev(s_p[1]),
    .ext_bus2(ext_bus[0]), .ext_bus3(ext_bus[1]), .ext_flags2(ext_flg[0]),
    .ext_flags3(ext_flg[1]),
    .u0_ret, .u0_rten, .u0_res, .u1_ret, .u1_rten, .u1_res
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  function logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  function word_t rand_word();
    logic [31:0] hi;
    hi = next_rand();
    return {hi, next_rand()};
  endfunction

  // no source or one of the four current or four previous buses.
  function logic [7:0] rand_src();
    logic [31:0] r;
    r = next_rand() % 9;
    return (r == 0) ? 8'd0 : (8'd1 << (r - 1));
  endfunction

  function automatic logic is_shift_op(input op_t op);
    return (op == op_shl64) || (op == op_shr64) || (op == op_sar64) ||
           (op == op_shl32) || (op == op_shr32) || (op == op_sar32);
  endfunction

  function automatic word_t pick_src(input word_t rv, input fwd_sel_t f, input fwd_sel_t p,
                                     input word_t cur [num_buses], input word_t prv [num_buses]);
    word_t v;
    v = rv;
    for (int i = 0; i < num_buses; i++) begin
      if (f[i]) v = cur[i];
      else if (p[i]) v = prv[i];
    end
    return v;
  endfunction

  function automatic exp_t ref_exec(input op_t op, input word_t a, input word_t b,
                                    input flags_t s);
    exp_t        e;
    logic [64:0] wide;
    logic [31:0] lo;
    word_t       r;
    int          n;
    logic        w32, left, cy;
    e = '0;
    e.ok = 1'b1;
    e.flg = s; // untouched flags pass through.
    r = '0;
    lo = '0;
    w32 = (op == op_shl32) || (op == op_shr32) || (op == op_sar32);
    left = (op == op_shl32) || (op == op_shl64);
    n = w32 ? int'(b[4:0]) : int'(b[5:0]);
    case (op)
      op_add: begin
        wide = {1'b0, a} + {1'b0, b};
        r = wide[63:0];
        e.flg[fl_c] = wide[64];
        e.flg[fl_o] = (a[63] == b[63]) && (r[63] != a[63]);
        e.flg[fl_a] = ({1'b0, a[3:0]} + {1'b0, b[3:0]}) > 5'd15; // nibble carry.
      end
      op_sub, op_cmp: begin
        r = a - b;
        e.flg[fl_c] = (a < b); // borrow.
        e.flg[fl_o] = (a[63] != b[63]) && (r[63] != a[63]);
        e.flg[fl_a] = (a[3:0] < b[3:0]); // nibble borrow.
      end
      op_and, op_or, op_xor: begin
        r = (op == op_and) ? (a & b) : (op == op_or) ? (a | b) : (a ^ b);
        e.flg[fl_c] = 1'b0;
        e.flg[fl_o] = 1'b0;
      end
      op_shl64: r = a << n;
      op_shr64: r = a >> n;
      op_sar64: r = $signed(a) >>> n;
      op_shl32: lo = a[31:0] << n;
      op_shr32: lo = a[31:0] >> n;
      op_sar32: lo = $signed(a[31:0]) >>> n;
      default:  e.ok = 1'b0;
    endcase
    if (w32) r = {32'd0, lo};
    if (is_shift_op(op) && n != 0) begin
      cy = left ? (w32 ? a[32 - n] : a[64 - n]) : a[n - 1];
      e.flg[fl_c] = cy;
      e.flg[fl_z] = w32 ? (lo == 0) : (r == 0);
      e.flg[fl_s] = w32 ? r[31] : r[63];
      e.flg[fl_p] = ($countones(r[7:0]) % 2) == 0;
      e.flg[fl_o] = left ? (e.flg[fl_s] ^ cy) : (op == op_shr32) ? a[31] :
                    (op == op_shr64) ? a[63] : 1'b0;
    end else if (e.ok && !is_shift_op(op)) begin
      e.flg[fl_z] = (r == 0);
      e.flg[fl_s] = r[63];
      e.flg[fl_p] = ($countones(r[7:0]) % 2) == 0;
    end
    e.res = (op == op_cmp) ? '0 : r;
    return e;
  endfunction

  always @(posedge clk) begin : model
    word_t cur_b [num_buses];
    word_t cur_f [num_buses];
    word_t ra, rb, rs;
    exp_t  e;
    logic  take;
    cur_b = '{m_res[0], m_res[1], ext_bus[0], ext_bus[1]};
    cur_f = '{m_flg[0], m_flg[1], 64'(ext_flg[0]), 64'(ext_flg[1])};
    for (int l = 0; l < 2; l++) begin
      ra = pick_src(a_in[l], a_f[l], a_p[l], cur_b, m_bus_prev);
      rb = pick_src(b_in[l], b_f[l], b_p[l], cur_b, m_bus_prev);
      rs = pick_src(64'(s_in[l]), s_f[l], s_p[l], cur_f, m_flg_prev);
      e = ref_exec(op_in[l], ra, rb, rs[5:0]);
      take = en_in[l] && !except && e.ok && !(l == 0 && is_shift_op(op_in[l]));
      if (rst) begin
        m_rten[l] <= 1'b0;
        m_res[l] <= '0;
        m_flg[l] <= '0;
        m_ret[l] <= '0;
      end else begin
        m_rten[l] <= take;
        if (take) begin
          m_res[l] <= e.res;
          m_flg[l] <= 64'(e.flg);
          m_ret[l] <= {1'b0, 1'b1, e.flg};
          n_expected++;
        end
      end
    end
    m_bus_prev <= cur_b;
    m_flg_prev <= cur_f;
  end

  always @(posedge clk) begin : compare
    logic  g_rten [2];
    word_t g_res [2];
    ret_t  g_ret [2];
    g_rten = '{u0_rten, u1_rten};
    g_res = '{u0_res, u1_res};
    g_ret = '{u0_ret, u1_ret};
    for (int l = 0; l < 2 && !rst; l++) begin
      assert (g_rten[l] === m_rten[l]) else begin
        $display("ERROR %0t: lane %0d rten %b, expected %b", $time, l, g_rten[l], m_rten[l]);
        errors++;
      end
      assert (g_res[l] === m_res[l]) else begin
        $display("ERROR %0t: lane %0d res %h, expected %h", $time, l, g_res[l], m_res[l]);
        errors++;
      end
      if (g_rten[l] && m_rten[l]) begin
        n_got++;
        assert (g_ret[l] === m_ret[l]) else begin
          $display("ERROR %0t: lane %0d ret %h, expected %h", $time, l, g_ret[l], m_ret[l]);
          errors++;
        end
      end
    end
  end

  task drive_issue(input bit lane1_any, input bit fwd_on, input int exc_pct,
                   input int bad_pct, input bit always_en);
    logic [7:0]  sa, sb, ss;
    logic [31:0] r;
    op_t         op;
    @(posedge clk);
    for (int l = 0; l < 2; l++) begin
      op = alu_ops[next_rand() % 6];
      if (l == 1 && lane1_any && next_rand() % 2 == 1) op = sh_ops[next_rand() % 6];
      if (next_rand() % 100 < bad_pct) begin
        op = (l == 0 && next_rand() % 2 == 1) ? sh_ops[next_rand() % 6] : bad_ops[next_rand() % 3];
      end
      sa = fwd_on ? rand_src() : 8'd0;
      sb = fwd_on ? rand_src() : 8'd0;
      ss = fwd_on ? rand_src() : 8'd0;
      r = next_rand();
      en_in[l] <= always_en || (r[9:8] != 2'b00);
      op_in[l] <= op;
      a_in[l] <= rand_word();
      b_in[l] <= rand_word();
      s_in[l] <= r[5:0];
      a_f[l] <= sa[3:0];
      a_p[l] <= sa[7:4];
      b_f[l] <= sb[3:0];
      b_p[l] <= sb[7:4];
      s_f[l] <= ss[3:0];
      s_p[l] <= ss[7:4];
    end
    r = next_rand();
    except <= (next_rand() % 100 < exc_pct);
    ext_bus[0] <= rand_word();
    ext_bus[1] <= rand_word();
    ext_flg[0] <= r[5:0];
    ext_flg[1] <= r[13:8];
  endtask

  task drive_shift(input op_t op, input logic [5:0] amt);
    word_t w;
    @(posedge clk);
    w = rand_word();
    en_in[0] <= 1'b0;
    en_in[1] <= 1'b1;
    op_in[1] <= op;
    a_in[1] <= rand_word();
    b_in[1] <= {w[63:6], amt};
    s_in[1] <= w[13:8];
  endtask

  // go idle, then wait until every expected result has shown up.
  task wait_results();
    int cnt;
    @(posedge clk);
    for (int l = 0; l < 2; l++) begin
      en_in[l] <= 1'b0;
      {a_f[l], a_p[l], b_f[l], b_p[l], s_f[l], s_p[l]} <= '0;
    end
    except <= 1'b0;
    cnt = 0;
    @(negedge clk);
    while (n_got != n_expected && cnt < 20) begin
      @(negedge clk);
      cnt++;
    end
    if (n_got != n_expected) begin
      $display("timeout: %0d lane results never arrived", n_expected - n_got);
      timed_out = 1;
    end
  endtask

  task finish_test(input string name, input int err0);
    wait_results();
    if (errors == err0 && !timed_out) begin
      n_pass++;
      $display("test %s: pass", name);
    end else begin
      n_fail++;
      $display("test %s: fail, %0d errors", name, errors - err0);
    end
  endtask

  initial begin
    int          err0, got0;
    logic [31:0] r;
    rst = 1'b1;
    except = 1'b0;
    for (int l = 0; l < 2; l++) begin
      {en_in[l], op_in[l], a_in[l], b_in[l], s_in[l]} = '0;
      {a_f[l], a_p[l], b_f[l], b_p[l], s_f[l], s_p[l]} = '0;
      ext_bus[l] = '0;
      ext_flg[l] = '0;
    end
    repeat (10) @(posedge clk);
    rst <= 1'b0;

    err0 = errors;
    repeat (3) begin
      @(negedge clk);
      assert (u0_rten === 1'b0 && u1_rten === 1'b0 && u0_res === '0 && u1_res === '0)
      else begin
        $display("ERROR %0t: outputs not idle after reset", $time);
        errors++;
      end
    end
    finish_test("reset", err0);

    err0 = errors;
    repeat (100) drive_issue(1'b0, 1'b0, 0, 0, 1'b0);
    finish_test("alu random", err0);

    err0 = errors;
    for (int i = 0; i < 6; i++) begin
      for (int k = 0; k < 5; k++) begin
        r = next_rand();
        drive_shift(sh_ops[i], (k < 4) ? amts[k] : r[5:0]);
      end
    end
    finish_test("shifts", err0);

    err0 = errors;
    repeat (150) drive_issue(1'b1, 1'b1, 0, 0, 1'b0);
    finish_test("forwarding", err0);

    err0 = errors;
    repeat (150) drive_issue(1'b1, 1'b1, 25, 20, 1'b0);
    finish_test("except and illegal", err0);

    err0 = errors;
    got0 = n_got;
    repeat (200) drive_issue(1'b1, 1'b1, 0, 0, 1'b1);
    wait_results();
    assert (n_got - got0 == 400) else begin
      $display("ERROR %0t: %0d of 400 back-to-back results seen", $time, n_got - got0);
      errors++;
    end
    finish_test("back to back", err0);

    $display("summary: %0d tests passed, %0d failed, %0d results, %0d errors",
             n_pass, n_fail, n_got, errors);
    if (errors == 0 && n_fail == 0 && !timed_out) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: hw/fu_alu_cluster.sv
`timescale 1ns/10ps

module fu_alu_cluster (
  input  logic             clk,
  input  logic             rst,
  input  logic             except,
  input  logic             u0_clk_en,
  input  fu_pkg::op_t      u0_op,
  input  fu_pkg::word_t    u0_a,
  input  fu_pkg::word_t    u0_b,
  input  fu_pkg::flags_t   u0_s,
  input  fu_pkg::fwd_sel_t u0_a_fwd, u0_a_fwd_prev, u0_b_fwd, u0_b_fwd_prev,
  input  fu_pkg::fwd_sel_t u0_s_fwd, u0_s_fwd_prev,
  input  logic             u1_clk_en,
  input  fu_pkg::op_t      u1_op,
  input  fu_pkg::word_t    u1_a,
  input  fu_pkg::word_t    u1_b,
  input  fu_pkg::flags_t   u1_s,
  input  fu_pkg::fwd_sel_t u1_a_fwd, u1_a_fwd_prev, u1_b_fwd, u1_b_fwd_prev,
  input  fu_pkg::fwd_sel_t u1_s_fwd, u1_s_fwd_prev,
  input  fu_pkg::word_t    ext_bus2,
  input  fu_pkg::word_t    ext_bus3,
  input  fu_pkg::flags_t   ext_flags2,
  input  fu_pkg::flags_t   ext_flags3,
  output fu_pkg::ret_t     u0_ret,
  output logic             u0_rten,
  output fu_pkg::word_t    u0_res,
  output fu_pkg::ret_t     u1_ret,
  output logic             u1_rten,
  output fu_pkg::word_t    u1_res
);
  import fu_pkg::*;

  word_t  bus_cur [num_buses];
  word_t  bus_prv [num_buses];
  flags_t flg_cur [num_buses];
  flags_t flg_prv [num_buses];
  word_t  alu0_res, alu1_res, sh1_res;
  flags_t alu0_flg, alu1_flg, sh1_flg, u0_flg, u1_flg;
  logic   alu0_hit, alu1_hit, sh1_hit;

  fu_issue_if u0_iss ();
  fu_issue_if u1_iss ();

  assign bus_cur = '{u0_res, u1_res, ext_bus2, ext_bus3};
  assign flg_cur = '{u0_flg, u1_flg, ext_flags2, ext_flags3};

  always_ff @(posedge clk) begin
    bus_prv <= bus_cur; // previous-cycle copy, every cycle.
    flg_prv <= flg_cur;
  end

  assign u0_iss.clk_en = u0_clk_en;
  assign u0_iss.op     = u0_op;
  assign u0_iss.except = except;
  assign u1_iss.clk_en = u1_clk_en;
  assign u1_iss.op     = u1_op;
  assign u1_iss.except = except;

  operand_forward i_u0_a_fwd (.clk, .rst, .reg_val(u0_a), .fwd(u0_a_fwd),
    .fwd_prev(u0_a_fwd_prev), .bus(bus_cur), .bus_prev(bus_prv), .val(u0_iss.a));
  operand_forward i_u0_b_fwd (.clk, .rst, .reg_val(u0_b), .fwd(u0_b_fwd),
    .fwd_prev(u0_b_fwd_prev), .bus(bus_cur), .bus_prev(bus_prv), .val(u0_iss.b));
  operand_forward #(.payload_t(flags_t)) i_u0_s_fwd (.clk, .rst, .reg_val(u0_s),
    .fwd(u0_s_fwd), .fwd_prev(u0_s_fwd_prev), .bus(flg_cur), .bus_prev(flg_prv),
    .val(u0_iss.s));
  operand_forward i_u1_a_fwd (.clk, .rst, .reg_val(u1_a), .fwd(u1_a_fwd),
    .fwd_prev(u1_a_fwd_prev), .bus(bus_cur), .bus_prev(bus_prv), .val(u1_iss.a));
  operand_forward i_u1_b_fwd (.clk, .rst, .reg_val(u1_b), .fwd(u1_b_fwd),
    .fwd_prev(u1_b_fwd_prev), .bus(bus_cur), .bus_prev(bus_prv), .val(u1_iss.b));
  operand_forward #(.payload_t(flags_t)) i_u1_s_fwd (.clk, .rst, .reg_val(u1_s),
    .fwd(u1_s_fwd), .fwd_prev(u1_s_fwd_prev), .bus(flg_cur), .bus_prev(flg_prv),
    .val(u1_iss.s));

  // lane 0, alu only.
  int_alu i_alu0 (.iss(u0_iss), .res(alu0_res), .flg(alu0_flg), .hit(alu0_hit));
  result_stage i_res0 (.clk, .rst, .iss(u0_iss), .alu_res(alu0_res),
    .alu_flg(alu0_flg), .alu_hit(alu0_hit), .sh_res('0), .sh_flg('0),
    .sh_hit(1'b0), .bus(u0_res), .bus_flg(u0_flg), .ret(u0_ret), .rten(u0_rten));

  // lane 1, alu and shifter.
  int_alu i_alu1 (.iss(u1_iss), .res(alu1_res), .flg(alu1_flg), .hit(alu1_hit));
  int_shifter i_sh1 (.iss(u1_iss), .res(sh1_res), .flg(sh1_flg), .hit(sh1_hit));
  result_stage i_res1 (.clk, .rst, .iss(u1_iss), .alu_res(alu1_res),
    .alu_flg(alu1_flg), .alu_hit(alu1_hit), .sh_res(sh1_res), .sh_flg(sh1_flg),
    .sh_hit(sh1_hit), .bus(u1_res), .bus_flg(u1_flg), .ret(u1_ret), .rten(u1_rten));

endmodule

// File: hw/result_stage.sv
`timescale 1ns/10ps

module result_stage (
  input  logic           clk,
  input  logic           rst,
  fu_issue_if.exe        iss,
  input  fu_pkg::word_t  alu_res,
  input  fu_pkg::flags_t alu_flg,
  input  logic           alu_hit,
  input  fu_pkg::word_t  sh_res,
  input  fu_pkg::flags_t sh_flg,
  input  logic           sh_hit,
  output fu_pkg::word_t  bus,
  output fu_pkg::flags_t bus_flg,
  output fu_pkg::ret_t   ret,
  output logic           rten
);
  import fu_pkg::*;

  logic   take;
  flags_t sel_flg;

  assign take    = iss.clk_en && !iss.except && (alu_hit || sh_hit);
  assign sel_flg = alu_hit ? alu_flg : sh_flg;

  always_ff @(posedge clk) begin
    if (rst) begin
      bus     <= '0;
      bus_flg <= '0;
      ret     <= '0;
      rten    <= 1'b0;
    end else begin
      rten <= take; // one-cycle strobe.
      if (take) begin
        bus     <= alu_hit ? alu_res : sh_res;
        bus_flg <= sel_flg;
        ret     <= '{spare: 1'b0, done: 1'b1, flags: sel_flg};
      end
    end
  end

  // alu and shifter decode disjoint opcode sets.
  a_single_unit: assert property (
    @(posedge clk) disable iff (rst) !(alu_hit && sh_hit)
  ) else $error("result_stage: alu and shifter both claim the opcode");

endmodule

// File: hw/int_shifter.sv
`timescale 1ns/10ps

module int_shifter (
  fu_issue_if.exe       iss,
  output fu_pkg::word_t  res,
  output fu_pkg::flags_t flg,
  output logic           hit
);
  import fu_pkg::*;

  logic [64:0] ext; // one spare bit catches the last bit shifted out.
  logic [63:0] full;
  logic [5:0]  amt;
  logic        is32;
  logic        left;
  logic        cy;

  always_comb begin
    is32 = (iss.op == op_shl32) || (iss.op == op_shr32) || (iss.op == op_sar32);
    left = (iss.op == op_shl32) || (iss.op == op_shl64);
    amt  = is32 ? {1'b0, iss.b[4:0]} : iss.b[5:0];
    hit  = 1'b1;
    ext  = '0;
    case (iss.op)
      op_shl64: ext = {1'b0, iss.a} << amt;
      op_shr64: ext = {iss.a, 1'b0} >> amt;
      op_sar64: ext = $signed({iss.a, 1'b0}) >>> amt;
      op_shl32: ext = {33'd0, iss.a[31:0]} << amt;
      op_shr32: ext = {32'd0, iss.a[31:0], 1'b0} >> amt;
      op_sar32: ext = $signed({{32{iss.a[31]}}, iss.a[31:0], 1'b0}) >>> amt;
      default:  hit = 1'b0;
    endcase
    full = left ? ext[63:0] : ext[64:1];
    cy   = left ? (is32 ? ext[32] : ext[64]) : ext[0];
    res  = is32 ? {32'd0, full[31:0]} : full; // 32-bit results zero-extend.
  end

  always_comb begin
    flg       = iss.s;
    if (amt != 6'd0) begin // count of zero keeps incoming flags.
      flg[fl_c] = cy;
      flg[fl_z] = is32 ? (res[31:0] == 32'd0) : (res == 64'd0);
      flg[fl_s] = is32 ? res[31] : res[63];
      flg[fl_p] = ~^res[7:0];
      if (left) begin
        flg[fl_o] = flg[fl_s] ^ cy;
      end else if ((iss.op == op_shr32) || (iss.op == op_shr64)) begin
        flg[fl_o] = is32 ? iss.a[31] : iss.a[63];
      end else begin
        flg[fl_o] = 1'b0;
      end
    end
  end

endmodule

// File: hw/int_alu.sv
`timescale 1ns/10ps

module int_alu (
  fu_issue_if.exe       iss,
  output fu_pkg::word_t  res,
  output fu_pkg::flags_t flg,
  output logic           hit
);
  import fu_pkg::*;

  logic [64:0] sum;
  logic        arith;
  logic        is_sub;

  always_comb begin
    sum    = '0;
    arith  = 1'b0;
    is_sub = 1'b0;
    hit    = 1'b1;
    case (iss.op)
      op_add: begin
        sum   = {1'b0, iss.a} + {1'b0, iss.b};
        arith = 1'b1;
      end
      op_sub, op_cmp: begin
        sum    = {1'b0, iss.a} - {1'b0, iss.b}; // bit 64 is the borrow.
        arith  = 1'b1;
        is_sub = 1'b1;
      end
      op_and:  sum = {1'b0, iss.a & iss.b};
      op_or:   sum = {1'b0, iss.a | iss.b};
      op_xor:  sum = {1'b0, iss.a ^ iss.b};
      default: hit = 1'b0;
    endcase
  end

  always_comb begin
    flg       = '0;
    flg[fl_c] = arith & sum[64];
    flg[fl_z] = (sum[63:0] == 64'd0);
    flg[fl_s] = sum[63];
    flg[fl_p] = ~^sum[7:0];
    // signed overflow.
    if (arith) begin
      flg[fl_o] = ((iss.a[63] ^ iss.b[63]) == is_sub) && (sum[63] != iss.a[63]);
      flg[fl_a] = iss.a[4] ^ iss.b[4] ^ sum[4];
    end else begin
      flg[fl_o] = 1'b0;
      flg[fl_a] = iss.s[fl_a]; // logic ops leave aux carry alone.
    end
  end

  // compare only produces flags.
  assign res = (iss.op == op_cmp) ? 64'd0 : sum[63:0];

endmodule

// File: hw/operand_forward.sv
`timescale 1ns/10ps

module operand_forward #(
  parameter type payload_t = fu_pkg::word_t
) (
  input  logic             clk,
  input  logic             rst,
  input  payload_t         reg_val,
  input  fu_pkg::fwd_sel_t fwd,
  input  fu_pkg::fwd_sel_t fwd_prev,
  input  payload_t         bus [fu_pkg::num_buses],
  input  payload_t         bus_prev [fu_pkg::num_buses],
  output payload_t         val
);
  import fu_pkg::*;

  always_comb begin
    val = reg_val; // no forward, register file value.
    for (int i = 0; i < num_buses; i++) begin
      if (fwd[i]) begin
        val = bus[i];
      end
      if (fwd_prev[i]) begin
        val = bus_prev[i]; // bus contents of one cycle back.
      end
    end
  end

  // current and previous selects together pick at most one source.
  a_sel_onehot: assert property (
    @(posedge clk) disable iff (rst) $onehot0({fwd, fwd_prev})
  ) else $error("operand_forward: more than one forward source selected");

endmodule

// File: hw/fu_issue_if.sv
`timescale 1ns/10ps

interface fu_issue_if;
  import fu_pkg::*;

  logic   clk_en;
  op_t    op;
  word_t  a;
  word_t  b;
  flags_t s;
  logic   except; // cancels this cycle's issue.

  modport fwd (
    output clk_en, op, a, b, s, except
  );

  modport exe (
    input clk_en, op, a, b, s, except
  );

endinterface

// File: hw/fu_pkg.sv
package fu_pkg;

  typedef logic [63:0] word_t;
  typedef logic [5:0]  flags_t;
  typedef logic [7:0]  op_t;

  // flag bit positions inside flags_t.
  localparam int fl_c = 0;
  localparam int fl_z = 1;
  localparam int fl_s = 2;
  localparam int fl_o = 3;
  localparam int fl_p = 4;
  localparam int fl_a = 5;

  // alu opcodes.
  localparam op_t op_add   = 8'h01;
  localparam op_t op_sub   = 8'h02;
  localparam op_t op_and   = 8'h03;
  localparam op_t op_or    = 8'h04;
  localparam op_t op_xor   = 8'h05;
  localparam op_t op_cmp   = 8'h06;
  // shifter opcodes.
  localparam op_t op_shl64 = 8'h10;
  localparam op_t op_shr64 = 8'h11;
  localparam op_t op_sar64 = 8'h12;
  localparam op_t op_shl32 = 8'h14;
  localparam op_t op_shr32 = 8'h15;
  localparam op_t op_sar32 = 8'h16;

  localparam int num_buses = 4; // two own lanes, two external.

  typedef logic [num_buses-1:0] fwd_sel_t; // one-hot, zero means no forward.

  typedef struct packed {
    logic   spare; // always zero.
    logic   done;
    flags_t flags;
  } ret_t;

endpackage
